/* tb.f */
hdl/cpu_pkg.sv
hdl/cpu_timing.sv
hdl/cpu_decoder.sv
hdl/cpu_regs.sv
hdl/cpu_arith.sv
hdl/cpu.sv
bench/cpu_checker.sv
bench/tb_cpu.sv

/* Bender.yml */
package:
  name: cpu

sources:
  - hdl/cpu_pkg.sv
  - hdl/cpu_timing.sv
  - hdl/cpu_decoder.sv
  - hdl/cpu_regs.sv
  - hdl/cpu_arith.sv
  - hdl/cpu.sv
  - target: test
    files:
      - bench/cpu_checker.sv
      - bench/tb_cpu.sv

/* bench/tb_cpu.sv */
// --------------------
// cpu testbench
// memory model with random ok delay, program table run entry by entry
// --------------------

`timescale 1ns/1ps

module tb_cpu;

	localparam int n_entries  = 4;
	localparam int max_words  = 48;
	localparam int max_writes = 8;
	localparam int watchdog_ns = n_entries * 64 * 8 * 40;

	logic              clk;
	logic              rst_n;
	logic              start;
	cpu_pkg::word_t    kl;
	logic              run, hlt;
	cpu_pkg::bus_out_t bus;
	cpu_pkg::word_t    rdt;
	logic              ok;

	logic [15:0] mem [0:65535];
	int          wait_cnt;

	// program table
	logic [15:0] tbl_start    [n_entries];
	int          tbl_len      [n_entries];
	logic [15:0] tbl_prog     [n_entries][max_words];
	int          tbl_nexp     [n_entries];
	logic [15:0] tbl_exp_addr [n_entries][max_writes];
	logic [15:0] tbl_exp_data [n_entries][max_writes];

	cpu cpu_inst(
		.__clk(clk), .rst_n(rst_n), .start(start), .kl(kl), .run(run), .hlt(hlt),
		.bus(bus), .rdt(rdt), .ok(ok)
	);

	cpu_checker cpu_checker_inst(
		.clk(clk), .rst_n(rst_n), .bus(bus), .ok(ok), .run(run), .hlt(hlt)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// opcode bits 0..3, ra 4..6, rb 7..9
	function automatic logic [15:0] encode(input logic [3:0] op, input logic [2:0] ra,
		input logic [2:0] rb);
		return {op, ra, rb, 6'b0};
	endfunction

	task automatic put_word(input int e, input logic [15:0] w);
		tbl_prog[e][tbl_len[e]] = w;
		tbl_len[e]++;
	endtask

	task automatic put_lw(input int e, input logic [2:0] r, input logic [15:0] val);
		put_word(e, encode(cpu_pkg::op_lw, r, 3'd0));
		put_word(e, val);
	endtask

	task automatic put_write(input int e, input logic [15:0] addr, input logic [15:0] data);
		tbl_exp_addr[e][tbl_nexp[e]] = addr;
		tbl_exp_data[e][tbl_nexp[e]] = data;
		tbl_nexp[e]++;
	endtask

	// r3 = a op b stored at addr
	task automatic put_alu_case(input int e, input logic [3:0] op, input logic [15:0] a,
		input logic [15:0] b, input logic [15:0] addr, input logic [15:0] result);
		put_lw(e, 3'd3, a);
		put_lw(e, 3'd2, b);
		put_word(e, encode(op, 3'd3, 3'd2));
		put_lw(e, 3'd4, addr);
		put_word(e, encode(cpu_pkg::op_rw, 3'd3, 3'd4));
		put_write(e, addr, result);
	endtask

	task automatic build_table();
		logic [15:0] a, b, v;
		a = 16'h1f2e;
		b = 16'hf0f3;
		v = $urandom;
		for (int e = 0; e < n_entries; e++) begin
			tbl_len[e] = 0;
			tbl_nexp[e] = 0;
		end
		// constant to memory
		tbl_start[0] = 16'h0100;
		put_lw(0, 3'd1, 16'hbeef);
		put_lw(0, 3'd2, 16'h0800);
		put_word(0, encode(cpu_pkg::op_rw, 3'd1, 3'd2));
		put_word(0, encode(cpu_pkg::op_hlt, 3'd0, 3'd0));
		put_write(0, 16'h0800, 16'hbeef);
		// --------------------
		// alu ops with 16-bit wrap
		// --------------------
		tbl_start[1] = 16'h0200;
		put_alu_case(1, cpu_pkg::op_aw, a, b, 16'h0900, 16'h1021); // carry out dropped
		put_alu_case(1, cpu_pkg::op_ac, a, b, 16'h0901, 16'h2e3b); // borrow dropped
		put_alu_case(1, cpu_pkg::op_nr, a, b, 16'h0902, 16'h1022);
		put_alu_case(1, cpu_pkg::op_or, a, b, 16'h0903, 16'hffff);
		put_alu_case(1, cpu_pkg::op_er, a, b, 16'h0904, 16'hefdd);
		put_word(1, encode(cpu_pkg::op_hlt, 3'd0, 3'd0));
		// memory read and copy of the data word after hlt
		tbl_start[2] = 16'h0300;
		put_lw(2, 3'd1, 16'h0307);
		put_word(2, encode(cpu_pkg::op_tw, 3'd2, 3'd1));
		put_lw(2, 3'd3, 16'h0a00);
		put_word(2, encode(cpu_pkg::op_rw, 3'd2, 3'd3));
		put_word(2, encode(cpu_pkg::op_hlt, 3'd0, 3'd0));
		put_word(2, 16'h5a3c);
		put_write(2, 16'h0a00, 16'h5a3c);
		// random value, unknown opcode, xor with itself
		tbl_start[3] = 16'h7ff8;
		put_lw(3, 3'd5, v);
		put_word(3, 16'hf000);
		put_lw(3, 3'd6, 16'h0b00);
		put_word(3, encode(cpu_pkg::op_rw, 3'd5, 3'd6));
		put_word(3, encode(cpu_pkg::op_er, 3'd5, 3'd5));
		put_word(3, encode(cpu_pkg::op_rw, 3'd5, 3'd6));
		put_word(3, encode(cpu_pkg::op_hlt, 3'd0, 3'd0));
		put_write(3, 16'h0b00, v);
		put_write(3, 16'h0b00, 16'h0000);
	endtask

	// --------------------
	// memory model
	// --------------------
	always @(negedge clk) begin
		if (!rst_n) begin
			ok <= 1'b0;
			wait_cnt = $urandom % 6;
		end else if (ok) begin
			ok <= 1'b0; // one-cycle pulse
			wait_cnt = $urandom % 6;
		end else if (bus.dr || bus.dw) begin
			if (wait_cnt == 0) begin
				ok <= 1'b1;
				if (bus.dw) mem[bus.dad] = bus.ddt;
				else rdt <= mem[bus.dad];
			end else begin
				wait_cnt--;
			end
		end
	end

	initial begin
		#(watchdog_ns);
		$display("timeout, the cpu did not halt in time");
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		start = 1'b0;
		kl = '0;
		rdt = '0;
		ok = 1'b0;
		void'($urandom(32'hab6dbdc6));
		build_table();
		for (int e = 0; e < n_entries; e++) begin
			@(negedge clk);
			rst_n = 1'b0;
			for (int i = 0; i < 65536; i++) begin
				mem[i] = {i[7:0], i[15:8]} ^ 16'h3c96; // fill pattern from the whole address
			end
			for (int i = 0; i < tbl_len[e]; i++) begin
				mem[16'(tbl_start[e] + i)] = tbl_prog[e][i];
			end
			cpu_checker_inst.begin_entry(tbl_start[e]);
			for (int i = 0; i < tbl_nexp[e]; i++) begin
				cpu_checker_inst.expect_write(tbl_exp_addr[e][i], tbl_exp_data[e][i]);
			end
			repeat (4) @(negedge clk);
			rst_n = 1'b1;
			@(negedge clk);
			start = 1'b1;
			kl = tbl_start[e];
			@(negedge clk);
			start = 1'b0;
			while (!hlt) @(negedge clk);
			repeat (4) @(negedge clk); // bus must stay quiet
		end
		$display("run complete, %0d entries, %0d errors", n_entries, cpu_checker_inst.err_cnt);
		if (cpu_checker_inst.err_cnt == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

/* bench/cpu_checker.sv */
// --------------------
// cpu bus checker
// compares bus writes with the expected list, watches first fetch and halt
// --------------------

`timescale 1ns/1ps

module cpu_checker(
	input                    clk,
	input                    rst_n,
	input cpu_pkg::bus_out_t bus,
	input                    ok,
	input                    run,
	input                    hlt
);

	logic [15:0] exp_addr_q [$];
	logic [15:0] exp_data_q [$];
	logic [15:0] start_addr;
	logic [15:0] ea, ed;
	logic        first_rd = 1'b0;
	logic        hlt_d = 1'b0;
	int          err_cnt = 0;

	// called by the bench while the dut sits in reset
	task automatic begin_entry(input logic [15:0] addr);
		exp_addr_q.delete();
		exp_data_q.delete();
		start_addr = addr;
		first_rd = 1'b1;
	endtask

	task automatic expect_write(input logic [15:0] addr, input logic [15:0] data);
		exp_addr_q.push_back(addr);
		exp_data_q.push_back(data);
	endtask

	always @(posedge clk) begin
		if (!rst_n) begin
			hlt_d <= 1'b0;
		end else begin
			hlt_d <= hlt;

			// --------------------
			// first strobe after start
			// --------------------
			if (first_rd && (bus.dr || bus.dw)) begin
				first_rd = 1'b0;
				if (!bus.dr) begin
					$display("first bus cycle after start is not a read");
					err_cnt++;
				end else if (bus.dad !== start_addr) begin
					$display("ERROR bus.dad: got %h expected %h", bus.dad, start_addr);
					err_cnt++;
				end
				if (run !== 1'b1) begin
					$display("run is not high during the first fetch");
					err_cnt++;
				end
			end

			// completed writes, in order
			if (bus.dw && ok) begin
				if (exp_addr_q.size() == 0) begin
					$display("extra write to address %h, none expected", bus.dad);
					err_cnt++;
				end else begin
					ea = exp_addr_q.pop_front();
					ed = exp_data_q.pop_front();
					if (bus.dad !== ea) begin
						$display("ERROR bus.dad: got %h expected %h", bus.dad, ea);
						err_cnt++;
					end
					if (bus.ddt !== ed) begin
						$display("ERROR bus.ddt: got %h expected %h", bus.ddt, ed);
						err_cnt++;
					end
				end
			end

			// --------------------
			// halt
			// --------------------
			if (hlt && !hlt_d) begin
				if (run !== 1'b0) begin
					$display("run still high after halt");
					err_cnt++;
				end
				if (exp_addr_q.size() != 0) begin
					$display("halted with %0d expected writes missing", exp_addr_q.size());
					err_cnt++;
				end
			end
			if (hlt && (bus.dr || bus.dw)) begin
				$display("bus strobe seen while halted");
				err_cnt++;
			end
		end
	end

endmodule

/* hdl/cpu.sv */
// --------------------
// cpu top level
// sequencer, decoder, registers and arithmetic tied to bus and panel
// --------------------

`timescale 1ns/1ps

module cpu(
	input                     __clk,
	input                     rst_n,

	// control panel
	input                     start,
	input  cpu_pkg::word_t    kl,
	output logic              run,
	output logic              hlt,

	// memory bus
	output cpu_pkg::bus_out_t bus,
	input  cpu_pkg::word_t    rdt,
	input                     ok
);

	cpu_pkg::phase_t phase;
	cpu_pkg::ctrl_t  ctrl;
	logic            ir_load, ic_step, ar_load, reg_we;
	logic            flags_we, z_alu, c_alu;
	cpu_pkg::word_t  qa, qb, wdata;

	cpu_timing timing(
		.__clk(__clk), .rst_n(rst_n), .start(start), .ok(ok), .ctrl(ctrl),
		.phase(phase), .ir_load(ir_load), .ic_step(ic_step), .ar_load(ar_load),
		.reg_we(reg_we), .run(run), .hlt(hlt)
	);

	cpu_decoder decoder(
		.__clk(__clk), .rst_n(rst_n), .ir_load(ir_load), .rdt(rdt), .ctrl(ctrl)
	);

	cpu_regs regs(
		.__clk(__clk), .rst_n(rst_n), .ra(ctrl.ra), .rb(ctrl.rb), .we(reg_we),
		.wdata(wdata), .flags_we(flags_we), .z_in(z_alu), .c_in(c_alu),
		.qa(qa), .qb(qb), .z(), .c()
	);

	cpu_arith arith(
		.__clk(__clk), .rst_n(rst_n), .phase(phase), .ctrl(ctrl), .kl(kl),
		.start(start), .ic_step(ic_step), .ar_load(ar_load), .qa(qa), .qb(qb),
		.rdt(rdt), .wdata(wdata), .flags_we(flags_we), .z_out(z_alu),
		.c_out(c_alu), .bus(bus)
	);

endmodule

/* hdl/cpu_arith.sv */
// --------------------
// cpu arithmetic and address path
// alu, instruction counter, address register, bus address/data
// --------------------

`timescale 1ns/1ps

module cpu_arith(
	input                      __clk,
	input                      rst_n,
	input  cpu_pkg::phase_t    phase,
	input  cpu_pkg::ctrl_t     ctrl,
	input  cpu_pkg::word_t     kl,
	input                      start,
	input                      ic_step,
	input                      ar_load,
	input  cpu_pkg::word_t     qa,
	input  cpu_pkg::word_t     qb,
	input  cpu_pkg::word_t     rdt,
	output cpu_pkg::word_t     wdata,
	output logic               flags_we,
	output logic               z_out,
	output logic               c_out,
	output cpu_pkg::bus_out_t  bus
);

	cpu_pkg::word_t ic;      // instruction counter
	cpu_pkg::word_t ar;      // memory operand address
	cpu_pkg::word_t alu_res;
	logic           alu_c;

	// --------------------
	// ic and ar
	// --------------------
	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			ic <= '0;
		end else if (start && (phase == cpu_pkg::ph_stop)) begin
			ic <= kl; // panel keys
		end else if (ic_step) begin
			ic <= ic + 1'b1;
		end
	end

	always_ff @(posedge __clk) begin
		if (ar_load) ar <= qb;
	end

	// --------------------
	// alu
	// --------------------
	always_comb begin
		alu_res = qa;
		alu_c = 1'b0; // logic ops clear carry
		case (ctrl.op)
			cpu_pkg::op_aw: {alu_c, alu_res} = {1'b0, qa} + {1'b0, qb};
			cpu_pkg::op_ac: {alu_c, alu_res} = {1'b0, qa} - {1'b0, qb}; // carry is borrow
			cpu_pkg::op_nr: alu_res = qa & qb;
			cpu_pkg::op_or: alu_res = qa | qb;
			cpu_pkg::op_er: alu_res = qa ^ qb;
			default: alu_res = qa;
		endcase
	end

	assign flags_we = (phase == cpu_pkg::ph_exec) && ctrl.alu;
	assign z_out = (alu_res == '0);
	assign c_out = alu_c;

	// exec writes the alu, arg and mem write the bus word
	assign wdata = (phase == cpu_pkg::ph_exec) ? alu_res : rdt;

	// bus strobes, address and data from the phase
	always_comb begin
		bus = '0;
		case (phase)
			cpu_pkg::ph_fetch, cpu_pkg::ph_arg: begin
				bus.dr = 1'b1;
				bus.dad = ic;
			end
			cpu_pkg::ph_mem: begin
				bus.dr = ctrl.mem_rd;
				bus.dw = ctrl.mem_wr;
				bus.dad = ar;
				if (ctrl.mem_wr) bus.ddt = qa;
			end
			default: bus = '0;
		endcase
	end

endmodule

/* hdl/cpu_regs.sv */
// --------------------
// cpu general registers
// eight words, two read ports, one write port, zero and carry flags
// --------------------

`timescale 1ns/1ps

module cpu_regs(
	input                               __clk,
	input                               rst_n,
	input        [cpu_pkg::reg_aw-1:0] ra,
	input        [cpu_pkg::reg_aw-1:0] rb,
	input                               we,
	input  cpu_pkg::word_t              wdata,
	input                               flags_we,
	input                               z_in,
	input                               c_in,
	output cpu_pkg::word_t              qa,
	output cpu_pkg::word_t              qb,
	output logic                        z,
	output logic                        c
);

	cpu_pkg::word_t gr [cpu_pkg::reg_n];

	// write always targets ra
	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			for (int i = 0; i < cpu_pkg::reg_n; i++) begin
				gr[i] <= '0;
			end
		end else if (we) begin
			gr[ra] <= wdata;
		end
	end

	// flags follow alu instructions only
	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			z <= 1'b0;
			c <= 1'b0;
		end else if (flags_we) begin
			z <= z_in;
			c <= c_in;
		end
	end

	assign qa = gr[ra];
	assign qb = gr[rb];

endmodule

/* hdl/cpu_decoder.sv */
// --------------------
// cpu instruction decoder
// holds ir, decodes opcode and register fields
// --------------------

`timescale 1ns/1ps

module cpu_decoder(
	input                  __clk,
	input                  rst_n,
	input                  ir_load,
	input  cpu_pkg::word_t rdt,
	output cpu_pkg::ctrl_t ctrl
);

	logic [0:9]       ir; // bits 10..15 carry nothing
	cpu_pkg::opcode_t code;

	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			ir <= '0; // decodes as nop
		end else if (ir_load) begin
			ir <= rdt[0:9];
		end
	end

	assign code = cpu_pkg::opcode_t'(ir[0:3]);

	always_comb begin
		ctrl = '0;
		ctrl.op = cpu_pkg::op_nop;
		ctrl.ra = ir[4:6];
		ctrl.rb = ir[7:9];
		case (code)
			cpu_pkg::op_lw: begin
				ctrl.op = code;
				ctrl.need_arg = 1'b1;
			end
			cpu_pkg::op_tw: begin
				ctrl.op = code;
				ctrl.mem_rd = 1'b1;
			end
			cpu_pkg::op_rw: begin
				ctrl.op = code;
				ctrl.mem_wr = 1'b1;
			end
			cpu_pkg::op_aw, cpu_pkg::op_ac, cpu_pkg::op_nr,
			cpu_pkg::op_or, cpu_pkg::op_er: begin
				ctrl.op = code;
				ctrl.alu = 1'b1;
			end
			cpu_pkg::op_hlt: ctrl.op = code;
			default: ctrl.op = cpu_pkg::op_nop; // unknown codes
		endcase
	end

endmodule

/* hdl/cpu_timing.sv */
// --------------------
// cpu timing sequencer
// steps fetch/exec/arg/mem/halt phases and turns bus ok into load enables
// --------------------

`timescale 1ns/1ps

module cpu_timing(
	input                   __clk,
	input                   rst_n,
	input                   start,
	input                   ok,
	input  cpu_pkg::ctrl_t  ctrl,
	output cpu_pkg::phase_t phase,
	output logic            ir_load,
	output logic            ic_step,
	output logic            ar_load,
	output logic            reg_we,
	output logic            run,
	output logic            hlt
);

	cpu_pkg::phase_t phase_nxt;

	// --------------------
	// phase register
	// --------------------
	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			phase <= cpu_pkg::ph_stop;
		end else begin
			phase <= phase_nxt;
		end
	end

	// exec is the first phase with a valid ir, so it picks the rest
	always_comb begin
		phase_nxt = phase;
		case (phase)
			cpu_pkg::ph_stop:  if (start) phase_nxt = cpu_pkg::ph_fetch;
			cpu_pkg::ph_fetch: if (ok) phase_nxt = cpu_pkg::ph_exec;
			cpu_pkg::ph_exec: begin
				if (ctrl.op == cpu_pkg::op_hlt) phase_nxt = cpu_pkg::ph_halt;
				else if (ctrl.need_arg) phase_nxt = cpu_pkg::ph_arg;
				else if (ctrl.mem_rd || ctrl.mem_wr) phase_nxt = cpu_pkg::ph_mem;
				else phase_nxt = cpu_pkg::ph_fetch;
			end
			cpu_pkg::ph_arg:   if (ok) phase_nxt = cpu_pkg::ph_fetch;
			cpu_pkg::ph_mem:   if (ok) phase_nxt = cpu_pkg::ph_fetch;
			cpu_pkg::ph_halt:  phase_nxt = cpu_pkg::ph_halt; // only reset leaves
			default:           phase_nxt = cpu_pkg::ph_stop;
		endcase
	end

	// --------------------
	// load enables
	// --------------------
	assign ir_load = (phase == cpu_pkg::ph_fetch) && ok;
	assign ic_step = ((phase == cpu_pkg::ph_fetch) || (phase == cpu_pkg::ph_arg)) && ok;
	assign ar_load = (phase == cpu_pkg::ph_exec) && (ctrl.mem_rd || ctrl.mem_wr);

	// alu result, argument word or memory word into ra
	assign reg_we = ((phase == cpu_pkg::ph_exec) && ctrl.alu)
		|| ((phase == cpu_pkg::ph_arg) && ok)
		|| ((phase == cpu_pkg::ph_mem) && ok && ctrl.mem_rd);

	// panel lamps
	assign hlt = (phase == cpu_pkg::ph_halt);
	assign run = (phase != cpu_pkg::ph_stop) && (phase != cpu_pkg::ph_halt);

endmodule

/* hdl/cpu_pkg.sv */
// --------------------
// cpu shared definitions
// word and register sizes, opcode and phase codes, control and bus bundles
// --------------------

package cpu_pkg;

	localparam int word_w = 16;
	localparam int reg_n  = 8;
	localparam int reg_aw = 3;

	// bit 0 is the msb
	typedef logic [0:word_w-1] word_t;

	// instruction bits 0..3
	typedef enum logic [3:0] {
		op_nop = 4'd0,  // also what every unknown code becomes
		op_lw  = 4'd1,  // ra <= next word
		op_tw  = 4'd2,  // ra <= mem[rb]
		op_rw  = 4'd3,  // mem[rb] <= ra
		op_aw  = 4'd4,  // ra <= ra + rb
		op_ac  = 4'd5,  // ra <= ra - rb
		op_nr  = 4'd6,  // ra <= ra & rb
		op_or  = 4'd7,  // ra <= ra | rb
		op_er  = 4'd8,  // ra <= ra ^ rb
		op_hlt = 4'd9
	} opcode_t;

	// --------------------
	// sequencer phases
	// --------------------
	typedef enum logic [2:0] {
		ph_stop  = 3'd0,
		ph_fetch = 3'd1,
		ph_arg   = 3'd2,
		ph_exec  = 3'd3,
		ph_mem   = 3'd4,
		ph_halt  = 3'd5
	} phase_t;

	// decoded instruction
	typedef struct packed {
		opcode_t           op;
		logic [reg_aw-1:0] ra;
		logic [reg_aw-1:0] rb;
		logic              need_arg; // second word follows
		logic              mem_rd;
		logic              mem_wr;
		logic              alu;      // result goes back to ra
	} ctrl_t;

	// memory bus, driven side
	typedef struct packed {
		logic  dr;
		logic  dw;
		word_t dad;
		word_t ddt;
	} bus_out_t;

endpackage
